/* eu_reg_pkg.sv */
//////////////////////////////////////////////////
// Event unit register map
// Word offsets of the core registers and the
// encodings of the decoded register writes
//////////////////////////////////////////////////
package eu_reg_pkg;

  // word offsets inside the core register group
  localparam logic [3:0] REG_EVT_MASK          = 4'h0;
  localparam logic [3:0] REG_EVT_MASK_CLR      = 4'h1;
  localparam logic [3:0] REG_EVT_MASK_SET      = 4'h2;
  localparam logic [3:0] REG_IRQ_MASK          = 4'h3;
  localparam logic [3:0] REG_IRQ_MASK_CLR      = 4'h4;
  localparam logic [3:0] REG_IRQ_MASK_SET      = 4'h5;
  localparam logic [3:0] REG_CLK_STATUS        = 4'h6;
  localparam logic [3:0] REG_BUFFER            = 4'h7;
  localparam logic [3:0] REG_BUFFER_MASKED     = 4'h8;
  localparam logic [3:0] REG_BUFFER_IRQ_MASKED = 4'h9;
  localparam logic [3:0] REG_BUFFER_CLEAR      = 4'ha;
  localparam logic [3:0] REG_WAIT              = 4'he;
  localparam logic [3:0] REG_WAIT_CLEAR        = 4'hf;

  // how the written data is combined with the old value
  typedef enum logic [1:0] {
    WR_LOAD,
    WR_CLEAR,
    WR_SET
  } wr_mode_t;

  // register touched by a write
  typedef enum logic [1:0] {
    T_EVT_MASK,
    T_IRQ_MASK,
    T_BUF_CLR
  } reg_target_t;

endpackage

/* eu_core_pkg.sv */
//////////////////////////////////////////////////
// Event unit core definitions
// Widths, bus structs, decoded register write
// and the states of the core clock FSM
//////////////////////////////////////////////////
package eu_core_pkg;

  localparam int unsigned DATA_W     = 32;
  localparam int unsigned ADDR_W     = 8;
  localparam int unsigned NB_EVT_MAX = 32;

  // fast direct link request, wen high means read
  typedef struct packed {
    logic              req;
    logic              wen;
    logic [ADDR_W-1:0] add;
    logic [DATA_W-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic              gnt;
    logic              r_valid;
    logic [DATA_W-1:0] r_rdata;
  } bus_rsp_t;

  // one accepted register write, valid for a single cycle
  typedef struct packed {
    logic                    valid;
    eu_reg_pkg::reg_target_t target;
    eu_reg_pkg::wr_mode_t    mode;
    logic [DATA_W-1:0]       data;
  } reg_wr_t;

  typedef enum logic [2:0] {
    ACTIVE,
    SLEEP,
    WAKEUP,
    WAKEUP_DEL,
    WAKEUP_IRQ,
    IRQ_WHILE_SLEEP
  } clk_state_t;

endpackage

/* eu_bus_port.sv */
//////////////////////////////////////////////////
// Event unit bus port
// Decodes fast link accesses into register writes
// and wait requests, returns the read data
//////////////////////////////////////////////////
`timescale 1ns/10ps

module eu_bus_port (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  eu_core_pkg::bus_req_t          bus_req_i,
  output eu_core_pkg::bus_rsp_t          bus_rsp_o,
  input  logic                           allow_gnt_i,
  output eu_core_pkg::reg_wr_t           reg_wr_o,
  output logic                           sleep_req_o,
  output logic                           is_clear_o,
  input  logic [eu_core_pkg::DATA_W-1:0] evt_mask_i,
  input  logic [eu_core_pkg::DATA_W-1:0] irq_mask_i,
  input  logic [eu_core_pkg::DATA_W-1:0] buffer_i,
  input  logic [eu_core_pkg::DATA_W-1:0] buffer_masked_i,
  input  logic [eu_core_pkg::DATA_W-1:0] buffer_irq_masked_i,
  input  logic                           clock_en_i
);

  logic       grp_zero;
  logic [3:0] offs;
  logic       is_wait;
  logic       accept;

  // access kept for the response cycle
  logic                           rvalid_q;
  logic                           rd_q;
  logic [eu_core_pkg::ADDR_W-1:0] add_q;
  logic [eu_core_pkg::DATA_W-1:0] rdata;

  assign grp_zero = (bus_req_i.add[eu_core_pkg::ADDR_W-1:4] == '0);
  assign offs     = bus_req_i.add[3:0];

  assign is_wait     = grp_zero & ((offs == eu_reg_pkg::REG_WAIT) |
                                   (offs == eu_reg_pkg::REG_WAIT_CLEAR));
  assign is_clear_o  = grp_zero & (offs == eu_reg_pkg::REG_WAIT_CLEAR);
  assign sleep_req_o = bus_req_i.req & bus_req_i.wen & is_wait;

  // only a wait read can see the grant withheld
  assign accept = bus_req_i.req & allow_gnt_i;

  assign bus_rsp_o.gnt     = accept;
  assign bus_rsp_o.r_valid = rvalid_q;
  assign bus_rsp_o.r_rdata = rdata;

  always_comb begin
    reg_wr_o      = '0;
    reg_wr_o.data = bus_req_i.wdata;
    if (accept && !bus_req_i.wen && grp_zero) begin
      reg_wr_o.valid = 1'b1;
      case (offs)
        eu_reg_pkg::REG_EVT_MASK: begin
          reg_wr_o.target = eu_reg_pkg::T_EVT_MASK;
          reg_wr_o.mode   = eu_reg_pkg::WR_LOAD;
        end
        eu_reg_pkg::REG_EVT_MASK_CLR: begin
          reg_wr_o.target = eu_reg_pkg::T_EVT_MASK;
          reg_wr_o.mode   = eu_reg_pkg::WR_CLEAR;
        end
        eu_reg_pkg::REG_EVT_MASK_SET: begin
          reg_wr_o.target = eu_reg_pkg::T_EVT_MASK;
          reg_wr_o.mode   = eu_reg_pkg::WR_SET;
        end
        eu_reg_pkg::REG_IRQ_MASK: begin
          reg_wr_o.target = eu_reg_pkg::T_IRQ_MASK;
          reg_wr_o.mode   = eu_reg_pkg::WR_LOAD;
        end
        eu_reg_pkg::REG_IRQ_MASK_CLR: begin
          reg_wr_o.target = eu_reg_pkg::T_IRQ_MASK;
          reg_wr_o.mode   = eu_reg_pkg::WR_CLEAR;
        end
        eu_reg_pkg::REG_IRQ_MASK_SET: begin
          reg_wr_o.target = eu_reg_pkg::T_IRQ_MASK;
          reg_wr_o.mode   = eu_reg_pkg::WR_SET;
        end
        eu_reg_pkg::REG_BUFFER_CLEAR: begin
          reg_wr_o.target = eu_reg_pkg::T_BUF_CLR;
          reg_wr_o.mode   = eu_reg_pkg::WR_CLEAR;
        end
        // writes to read-only offsets are dropped
        default: reg_wr_o.valid = 1'b0;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
      rd_q     <= 1'b0;
      add_q    <= '0;
    end else begin
      rvalid_q <= accept;
      rd_q     <= accept & bus_req_i.wen;
      if (accept) begin
        add_q <= bus_req_i.add;
      end
    end
  end

  // read data in the response cycle, zero for writes
  always_comb begin
    rdata = '0;
    if (rd_q && (add_q[eu_core_pkg::ADDR_W-1:4] == '0)) begin
      case (add_q[3:0])
        eu_reg_pkg::REG_EVT_MASK:          rdata = evt_mask_i;
        eu_reg_pkg::REG_IRQ_MASK:          rdata = irq_mask_i;
        eu_reg_pkg::REG_CLK_STATUS:        rdata[0] = clock_en_i;
        eu_reg_pkg::REG_BUFFER:            rdata = buffer_i;
        eu_reg_pkg::REG_BUFFER_MASKED:     rdata = buffer_masked_i;
        eu_reg_pkg::REG_BUFFER_IRQ_MASKED: rdata = buffer_irq_masked_i;
        eu_reg_pkg::REG_WAIT:              rdata = buffer_masked_i;
        eu_reg_pkg::REG_WAIT_CLEAR:        rdata = buffer_masked_i;
        default:                           rdata = '0;
      endcase
    end
  end

endmodule

/* eu_event_regs.sv */
//////////////////////////////////////////////////
// Event unit registers
// Event mask, irq mask and the event buffer
//////////////////////////////////////////////////
`timescale 1ns/10ps

module eu_event_regs #(
  parameter int unsigned NB_EVT = 32
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  eu_core_pkg::reg_wr_t               reg_wr_i,
  input  logic                               clear_masked_i,
  input  logic [eu_core_pkg::NB_EVT_MAX-1:0] evt_lines_i,
  input  logic                               irq_ack_i,
  input  logic [4:0]                         irq_ack_id_i,
  output logic [eu_core_pkg::DATA_W-1:0]     evt_mask_o,
  output logic [eu_core_pkg::DATA_W-1:0]     irq_mask_o,
  output logic [eu_core_pkg::DATA_W-1:0]     buffer_o,
  output logic [eu_core_pkg::DATA_W-1:0]     buffer_masked_o,
  output logic [eu_core_pkg::DATA_W-1:0]     buffer_irq_masked_o,
  output logic                               evt_pending_o
);

  // lines above NB_EVT never get stored
  localparam logic [eu_core_pkg::DATA_W-1:0] USED_MASK =
    {eu_core_pkg::DATA_W{1'b1}} >> (eu_core_pkg::DATA_W - NB_EVT);

  logic [eu_core_pkg::DATA_W-1:0] evt_mask_q, evt_mask_d;
  logic [eu_core_pkg::DATA_W-1:0] irq_mask_q, irq_mask_d;
  logic [eu_core_pkg::DATA_W-1:0] buffer_q, buffer_d;
  logic [eu_core_pkg::DATA_W-1:0] buffer_base;
  logic [eu_core_pkg::DATA_W-1:0] ack_onehot;

  function automatic logic [eu_core_pkg::DATA_W-1:0] apply_wr(
    input logic [eu_core_pkg::DATA_W-1:0] old_val,
    input eu_reg_pkg::wr_mode_t           mode,
    input logic [eu_core_pkg::DATA_W-1:0] data
  );
    case (mode)
      eu_reg_pkg::WR_CLEAR: return old_val & ~data;
      eu_reg_pkg::WR_SET:   return old_val | data;
      default:              return data;
    endcase
  endfunction

  assign ack_onehot = irq_ack_i ?
                      ({{(eu_core_pkg::DATA_W-1){1'b0}}, 1'b1} << irq_ack_id_i) : '0;

  always_comb begin
    evt_mask_d  = evt_mask_q;
    irq_mask_d  = irq_mask_q;
    buffer_base = buffer_q;
    if (reg_wr_i.valid) begin
      case (reg_wr_i.target)
        eu_reg_pkg::T_EVT_MASK:
          evt_mask_d = apply_wr(evt_mask_q, reg_wr_i.mode, reg_wr_i.data) & USED_MASK;
        eu_reg_pkg::T_IRQ_MASK:
          irq_mask_d = apply_wr(irq_mask_q, reg_wr_i.mode, reg_wr_i.data) & USED_MASK;
        eu_reg_pkg::T_BUF_CLR:
          buffer_base = buffer_q & ~reg_wr_i.data;
        default: buffer_base = buffer_q;
      endcase
    end
    // wait_clear wins over a buffer-clear write in the same cycle
    if (clear_masked_i) begin
      buffer_base = buffer_q & ~evt_mask_q;
    end
    buffer_d = (buffer_base | (evt_lines_i & USED_MASK)) & ~ack_onehot;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      evt_mask_q <= '0;
      irq_mask_q <= '0;
      buffer_q   <= '0;
    end else begin
      evt_mask_q <= evt_mask_d;
      irq_mask_q <= irq_mask_d;
      buffer_q   <= buffer_d;
    end
  end

  assign evt_mask_o          = evt_mask_q;
  assign irq_mask_o          = irq_mask_q;
  assign buffer_o            = buffer_q;
  assign buffer_masked_o     = buffer_q & evt_mask_q;
  assign buffer_irq_masked_o = buffer_q & irq_mask_q;
  assign evt_pending_o       = |buffer_masked_o;

endmodule

/* eu_irq_sel.sv */
//////////////////////////////////////////////////
// Event unit interrupt select
// Highest pending irq id and registered request
//////////////////////////////////////////////////
`timescale 1ns/10ps

module eu_irq_sel #(
  parameter int unsigned NB_EVT = 32
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic [eu_core_pkg::DATA_W-1:0] buffer_irq_masked_i,
  input  logic                           irq_block_i,
  output logic                           irq_pending_o,
  output logic                           irq_req_o,
  output logic [4:0]                     irq_id_o
);

  logic irq_req_q;

  assign irq_pending_o = |buffer_irq_masked_i[NB_EVT-1:0];

  // later hits overwrite earlier ones, so the highest bit wins
  always_comb begin
    irq_id_o = '0;
    for (int i = 0; i < NB_EVT; i++) begin
      if (buffer_irq_masked_i[i]) begin
        irq_id_o = 5'(i);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_req_q <= 1'b0;
    end else begin
      irq_req_q <= irq_pending_o & ~irq_block_i;
    end
  end

  assign irq_req_o = irq_req_q;

endmodule

/* eu_sleep_fsm.sv */
//////////////////////////////////////////////////
// Event unit core clock FSM
// Gates the core clock on wait reads and wakes
// it on masked events or interrupts
//////////////////////////////////////////////////
`timescale 1ns/10ps

module eu_sleep_fsm (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic sleep_req_i,
  input  logic is_clear_i,
  input  logic evt_pending_i,
  input  logic irq_pending_i,
  input  logic irq_req_i,
  input  logic core_busy_i,
  output logic allow_gnt_o,
  output logic clear_masked_o,
  output logic irq_block_o,
  output logic clock_en_o
);

  eu_core_pkg::clk_state_t state_q, state_d;
  logic                    clear_d, clear_q;

  // hold back a new irq while a wait read is being served
  assign irq_block_o = sleep_req_i & ~irq_req_i &
                       ((state_q == eu_core_pkg::ACTIVE) ||
                        (state_q == eu_core_pkg::WAKEUP) ||
                        (state_q == eu_core_pkg::WAKEUP_DEL));

  always_comb begin
    state_d     = state_q;
    clock_en_o  = 1'b1;
    allow_gnt_o = 1'b1;
    clear_d     = 1'b0;

    case (state_q)
      eu_core_pkg::ACTIVE: begin
        if (sleep_req_i) begin
          if (irq_req_i) begin
            state_d = eu_core_pkg::IRQ_WHILE_SLEEP;
          end else if (evt_pending_i) begin
            // event already there, serve the wait at once
            clear_d = is_clear_i;
          end else begin
            allow_gnt_o = 1'b0;
            if (!core_busy_i) begin
              state_d = eu_core_pkg::SLEEP;
            end
          end
        end
      end
      eu_core_pkg::SLEEP: begin
        clock_en_o  = 1'b0;
        allow_gnt_o = 1'b0;
        if (irq_pending_i) begin
          clock_en_o = 1'b1;
          state_d    = eu_core_pkg::WAKEUP_IRQ;
        end else if (evt_pending_i) begin
          state_d = eu_core_pkg::WAKEUP;
        end
      end
      eu_core_pkg::WAKEUP_IRQ: begin
        state_d = eu_core_pkg::IRQ_WHILE_SLEEP;
      end
      eu_core_pkg::WAKEUP: begin
        if (is_clear_i) begin
          clear_d = 1'b1;
          // extra cycle so the clear lands before the next wait
          state_d = eu_core_pkg::WAKEUP_DEL;
        end else begin
          state_d = eu_core_pkg::ACTIVE;
        end
      end
      eu_core_pkg::WAKEUP_DEL: begin
        if (sleep_req_i) begin
          allow_gnt_o = 1'b0;
        end
        state_d = eu_core_pkg::ACTIVE;
      end
      eu_core_pkg::IRQ_WHILE_SLEEP: begin
        // wait for the core to replay its wait read
        if (sleep_req_i && !irq_pending_i) begin
          if (evt_pending_i) begin
            clear_d = is_clear_i;
            state_d = eu_core_pkg::WAKEUP;
          end else begin
            allow_gnt_o = 1'b0;
            if (!core_busy_i) begin
              state_d = eu_core_pkg::SLEEP;
            end
          end
        end
      end
      default: begin
        state_d = eu_core_pkg::ACTIVE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= eu_core_pkg::ACTIVE;
      clear_q <= 1'b0;
    end else begin
      state_q <= state_d;
      clear_q <= clear_d;
    end
  end

  assign clear_masked_o = clear_q;

endmodule

/* eu_top.sv */
//////////////////////////////////////////////////
// Event unit top
// Per-core event buffer, interrupts and clock gating
//////////////////////////////////////////////////
`timescale 1ns/10ps

module eu_top #(
  parameter int unsigned NB_EVT = 32
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  eu_core_pkg::bus_req_t              bus_req_i,
  output eu_core_pkg::bus_rsp_t              bus_rsp_o,
  input  logic [eu_core_pkg::NB_EVT_MAX-1:0] evt_lines_i,
  output logic                               irq_req_o,
  output logic [4:0]                         irq_id_o,
  input  logic                               irq_ack_i,
  input  logic [4:0]                         irq_ack_id_i,
  input  logic                               core_busy_i,
  output logic                               core_clock_en_o
);

  eu_core_pkg::reg_wr_t reg_wr;

  logic [eu_core_pkg::DATA_W-1:0] evt_mask;
  logic [eu_core_pkg::DATA_W-1:0] irq_mask;
  logic [eu_core_pkg::DATA_W-1:0] buffer;
  logic [eu_core_pkg::DATA_W-1:0] buffer_masked;
  logic [eu_core_pkg::DATA_W-1:0] buffer_irq_masked;

  logic sleep_req, is_clear, allow_gnt;
  logic clear_masked, irq_block;
  logic evt_pending, irq_pending;

  eu_bus_port i_bus_port (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .bus_req_i           (bus_req_i),
    .bus_rsp_o           (bus_rsp_o),
    .allow_gnt_i         (allow_gnt),
    .reg_wr_o            (reg_wr),
    .sleep_req_o         (sleep_req),
    .is_clear_o          (is_clear),
    .evt_mask_i          (evt_mask),
    .irq_mask_i          (irq_mask),
    .buffer_i            (buffer),
    .buffer_masked_i     (buffer_masked),
    .buffer_irq_masked_i (buffer_irq_masked),
    .clock_en_i          (core_clock_en_o)
  );

  eu_event_regs #(
    .NB_EVT (NB_EVT)
  ) i_event_regs (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .reg_wr_i            (reg_wr),
    .clear_masked_i      (clear_masked),
    .evt_lines_i         (evt_lines_i),
    .irq_ack_i           (irq_ack_i),
    .irq_ack_id_i        (irq_ack_id_i),
    .evt_mask_o          (evt_mask),
    .irq_mask_o          (irq_mask),
    .buffer_o            (buffer),
    .buffer_masked_o     (buffer_masked),
    .buffer_irq_masked_o (buffer_irq_masked),
    .evt_pending_o       (evt_pending)
  );

  eu_irq_sel #(
    .NB_EVT (NB_EVT)
  ) i_irq_sel (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .buffer_irq_masked_i (buffer_irq_masked),
    .irq_block_i         (irq_block),
    .irq_pending_o       (irq_pending),
    .irq_req_o           (irq_req_o),
    .irq_id_o            (irq_id_o)
  );

  eu_sleep_fsm i_sleep_fsm (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .sleep_req_i    (sleep_req),
    .is_clear_i     (is_clear),
    .evt_pending_i  (evt_pending),
    .irq_pending_i  (irq_pending),
    .irq_req_i      (irq_req_o),
    .core_busy_i    (core_busy_i),
    .allow_gnt_o    (allow_gnt),
    .clear_masked_o (clear_masked),
    .irq_block_o    (irq_block),
    .clock_en_o     (core_clock_en_o)
  );

endmodule

/* tb_eu_top.sv */
//////////////////////////////////////////////////
// Event unit testbench
// Runs the command list from the vector file
// against eu_top and checks every response
//////////////////////////////////////////////////
`timescale 1ns/10ps

module tb_eu_top;

  localparam int MAX_CMDS       = 64;
  localparam int CYCLES_PER_CMD = 200;

  logic                               clk;
  logic                               rst_n;
  eu_core_pkg::bus_req_t              bus_req;
  eu_core_pkg::bus_rsp_t              bus_rsp;
  logic [eu_core_pkg::NB_EVT_MAX-1:0] evt_lines;
  logic                               irq_req;
  logic [4:0]                         irq_id;
  logic                               irq_ack;
  logic [4:0]                         irq_ack_id;
  logic                               core_busy;
  logic                               core_clock_en;

  // four words per command: cmd, addr, data, expect
  logic [31:0] vec [0:4*MAX_CMDS-1];
  int          n_cmds;
  int          n_tests;
  int          errors;
  logic        loaded;

  eu_top #(
    .NB_EVT (32)
  ) i_dut (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .bus_req_i       (bus_req),
    .bus_rsp_o       (bus_rsp),
    .evt_lines_i     (evt_lines),
    .irq_req_o       (irq_req),
    .irq_id_o        (irq_id),
    .irq_ack_i       (irq_ack),
    .irq_ack_id_i    (irq_ack_id),
    .core_busy_i     (core_busy),
    .core_clock_en_o (core_clock_en)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_rdata(input logic [eu_core_pkg::DATA_W-1:0] got,
                             input logic [eu_core_pkg::DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("MISMATCH r_rdata: got %08h expected %08h", got, exp);
      errors++;
    end
  endtask

  task automatic check_irq(input logic [4:0] got, input logic [4:0] exp);
    if (got !== exp) begin
      $display("MISMATCH irq_id_o: got %02h expected %02h", got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got %0h expected %0h", name, got, exp);
      errors++;
    end
  endtask

  // called at the negedge that saw gnt, finishes the response cycle
  task automatic finish_access(input logic [31:0] exp);
    @(posedge clk);
    #2;
    bus_req = '0;
    @(negedge clk);
    check_flag("r_valid", bus_rsp.r_valid, 1'b1);
    check_rdata(bus_rsp.r_rdata, exp);
  endtask

  task automatic bus_access(input logic rd, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic [31:0] exp);
    @(posedge clk);
    #2;
    bus_req.req   = 1'b1;
    bus_req.wen   = rd;
    bus_req.add   = addr[eu_core_pkg::ADDR_W-1:0];
    bus_req.wdata = wdata;
    @(negedge clk);
    while (!bus_rsp.gnt) begin
      @(negedge clk);
    end
    finish_access(exp);
  endtask

  task automatic pulse_events(input logic [31:0] mask);
    @(posedge clk);
    #2 evt_lines = mask;
    @(posedge clk);
    #2 evt_lines = '0;
  endtask

  task automatic pulse_ack(input logic [4:0] id);
    @(posedge clk);
    #2;
    irq_ack    = 1'b1;
    irq_ack_id = id;
    @(posedge clk);
    #2 irq_ack = 1'b0;
  endtask

  // wait read that must sleep until the event is raised
  task automatic wait_for_event(input logic [31:0] addr, input logic [31:0] evt,
                                input logic [31:0] exp);
    @(posedge clk);
    #2;
    bus_req.req   = 1'b1;
    bus_req.wen   = 1'b1;
    bus_req.add   = addr[eu_core_pkg::ADDR_W-1:0];
    bus_req.wdata = '0;
    @(negedge clk);
    while (core_clock_en) begin
      check_flag("gnt", bus_rsp.gnt, 1'b0);
      @(negedge clk);
    end
    check_flag("gnt", bus_rsp.gnt, 1'b0);
    pulse_events(evt);
    @(negedge clk);
    while (!bus_rsp.gnt) begin
      @(negedge clk);
    end
    check_flag("core_clock_en_o", core_clock_en, 1'b1);
    finish_access(exp);
  endtask

  function automatic string cmd_name(input logic [31:0] c);
    case (c)
      32'd1:   return "write";
      32'd2:   return "read";
      32'd3:   return "event";
      32'd4:   return "irq";
      32'd5:   return "ack";
      32'd6:   return "wait";
      default: return "unknown";
    endcase
  endfunction

  initial begin : main
    logic [31:0] cmd;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] x;
    int          errs_before;
    bus_req    = '0;
    evt_lines  = '0;
    irq_ack    = 1'b0;
    irq_ack_id = '0;
    core_busy  = 1'b0;
    rst_n      = 1'b0;
    errors     = 0;
    n_tests    = 0;
    loaded     = 1'b0;
    $readmemh("eu_input_vectors.txt", vec);
    n_cmds = 0;
    while (n_cmds < MAX_CMDS && vec[4*n_cmds] != 32'h0) begin
      n_cmds++;
    end
    if (n_cmds == 0) begin
      $display("no commands could be read from eu_input_vectors.txt");
      errors++;
    end
    loaded = 1'b1;
    // outputs stay inactive while reset is held
    repeat (8) @(posedge clk);
    @(negedge clk);
    check_flag("gnt", bus_rsp.gnt, 1'b0);
    check_flag("r_valid", bus_rsp.r_valid, 1'b0);
    check_flag("irq_req_o", irq_req, 1'b0);
    check_flag("core_clock_en_o", core_clock_en, 1'b1);
    n_tests++;
    $display("test reset %s", (errors == 0) ? "ok" : "FAILED");
    @(posedge clk);
    #2 rst_n = 1'b1;
    for (int i = 0; i < n_cmds; i++) begin
      cmd         = vec[4*i];
      a           = vec[4*i+1];
      d           = vec[4*i+2];
      x           = vec[4*i+3];
      errs_before = errors;
      case (cmd)
        32'd1: bus_access(1'b0, a, d, 32'h0);
        32'd2: bus_access(1'b1, a, 32'h0, x);
        32'd3: pulse_events(d);
        32'd4: begin
          // request is registered one cycle after the buffer moves
          @(posedge clk);
          @(negedge clk);
          check_flag("irq_req_o", irq_req, d[0]);
          check_irq(irq_id, x[4:0]);
        end
        32'd5: pulse_ack(d[4:0]);
        32'd6: wait_for_event(a, d, x);
        default: begin
          $display("unknown command %0h in line %0d of the vector file", cmd, i);
          errors++;
        end
      endcase
      n_tests++;
      $display("test %0d %s %02h %s", i, cmd_name(cmd), a[7:0],
               (errors == errs_before) ? "ok" : "FAILED");
    end
    $display("%0d tests run, %0d errors", n_tests, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin : watchdog
    wait (loaded);
    repeat ((n_cmds + 1) * CYCLES_PER_CMD) @(posedge clk);
    $display("timeout: DUT gave no response within %0d cycles",
             (n_cmds + 1) * CYCLES_PER_CMD);
    $display("Errors found");
    $finish;
  end

endmodule

/* eu_input_vectors.txt */
// columns: cmd addr data expect, hex words, one command per line
// cmd 1 write, 2 read, 3 event pulse, 4 irq (data req, expect id), 5 ack, 6 wait, 0 end
02 00000000 00000000 00000000
02 00000003 00000000 00000000
02 00000006 00000000 00000001
02 00000007 00000000 00000000
02 00000008 00000000 00000000
02 00000009 00000000 00000000
04 00000000 00000000 00000000
01 00000000 ff00ff00 00000000
02 00000000 00000000 ff00ff00
01 00000001 0f000f00 00000000
02 00000000 00000000 f000f000
01 00000002 0000000f 00000000
02 00000000 00000000 f000f00f
01 00000003 12345678 00000000
02 00000003 00000000 12345678
01 00000004 00000070 00000000
02 00000003 00000000 12345608
01 00000005 80000001 00000000
02 00000003 00000000 92345609
01 00000003 00000000 00000000
03 00000000 00000011 00000000
03 00000000 00000300 00000000
02 00000007 00000000 00000311
02 00000008 00000000 00000001
01 0000000a 00000010 00000000
02 00000007 00000000 00000301
02 00000009 00000000 00000000
01 0000000a ffffffff 00000000
02 00000007 00000000 00000000
01 00000000 000000f0 00000000
06 0000000e 00000030 00000030
02 00000007 00000000 00000030
02 00000006 00000000 00000001
01 0000000a ffffffff 00000000
03 00000000 00000101 00000000
06 0000000f 00000050 00000050
02 00000007 00000000 00000101
02 00000008 00000000 00000000
01 0000000a ffffffff 00000000
01 00000003 00008421 00000000
03 00000000 00008403 00000000
04 00000000 00000001 0000000f
05 00000000 0000000f 00000000
04 00000000 00000001 0000000a
05 00000000 0000000a 00000000
04 00000000 00000001 00000000
05 00000000 00000000 00000000
04 00000000 00000000 00000000
02 00000007 00000000 00000002
00 00000000 00000000 00000000

/* verilog.f */
eu_reg_pkg.sv
eu_core_pkg.sv
eu_bus_port.sv
eu_event_regs.sv
eu_irq_sel.sv
eu_sleep_fsm.sv
eu_top.sv
tb_eu_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the event unit testbench with Verilator, runs it and checks the log.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f verilog.f --top-module tb_eu_top -o tb_eu_top
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_eu_top > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -qx "No errors" "$LOG"; then
  echo "simulation passed"
  exit 0
fi

echo "simulation failed, see $LOG"
exit 1
